// File: backup_sequencer.sv
// backup save and load sequencer
`timescale 1ns/1ps

module backup_sequencer (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      bk_load,
	input  logic                      bk_save,
	input  logic                      sector_done,
	input  logic                      last_sector_hit,
	input  logic [7:0]                lba,
	output logic                      step,
	output logic                      clear,
	output logic                      loading,
	output logic                      bk_busy,
	output gb_backup_pkg::sector_req_t sector_req
);

	typedef enum logic [1:0] {
		st_idle,
		st_request,     // request strobe cycle
		st_wait_done    // host moves the sector
	} bk_state_t;

	bk_state_t state;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= st_idle;
			loading <= 1'b0;
		end else begin
			case (state)
				st_idle: if (bk_load || bk_save) begin
					state   <= st_request;
					loading <= bk_load;   // load wins if both strobe together
				end
				st_request: state <= st_wait_done;
				st_wait_done: if (sector_done) begin
					if (last_sector_hit) begin
						state   <= st_idle;
						loading <= 1'b0;
					end else begin
						state <= st_request;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	assign clear   = (state == st_idle) && (bk_load || bk_save);   // lba back to 0
	assign step    = (state == st_wait_done) && sector_done && !last_sector_hit;
	assign bk_busy = (state != st_idle);

	assign sector_req.rd  = (state == st_request) && loading;
	assign sector_req.wr  = (state == st_request) && !loading;
	assign sector_req.lba = lba;

	a_done_when_busy: assert property (@(posedge clk_sys) disable iff (reset)
		(state == st_idle) |-> !sector_done)
		else $error("sector_done with no backup running");

endmodule

// File: cart_addr_map.sv
// cartridge address mapping and read response
`timescale 1ns/1ps

module cart_addr_map (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  gb_cart_pkg::cpu_req_t   cpu_req,
	input  gb_cart_pkg::bank_regs_t regs,
	input  gb_cart_pkg::cart_info_t cart_info,
	input  logic [7:0]              ram_q,
	output logic [16:0]             ram_addr,
	output logic                    ram_wr,
	output gb_cart_pkg::cpu_rsp_t   cpu_rsp
);

	logic [8:0]  rom_bank_eff;
	logic [3:0]  ram_bank_eff;
	logic [22:0] rom_addr_next;
	logic        is_rom, is_ram, rtc_mode;
	logic        rom_rd_q, ram_valid_q;
	logic [22:0] rom_addr_q;
	logic        off_q, rtc_q, mbc2_q;   // read data shaping for the pending read

	assign is_rom   = (cpu_req.addr[15] == 1'b0);         // 0000-7fff
	assign is_ram   = (cpu_req.addr[15:13] == 3'b101);    // a000-bfff
	assign rtc_mode = (cart_info.kind == gb_cart_pkg::mbc3) && regs.rtc_sel;

	always_comb begin
		case (cart_info.kind)
			// in mode 0 the ram bank lines drive rom bits 6:5
			gb_cart_pkg::mbc1: rom_bank_eff = regs.mbc1_mode ? {4'd0, regs.rom_bank[4:0]}
				: {2'b00, regs.ram_bank[1:0], regs.rom_bank[4:0]};
			gb_cart_pkg::mbc5: rom_bank_eff = regs.rom_bank;
			default:           rom_bank_eff = {2'b00, regs.rom_bank[6:0]};
		endcase
		if (((cart_info.kind == gb_cart_pkg::mbc1) && !regs.mbc1_mode)
			|| (cart_info.kind inside {gb_cart_pkg::mbc2, gb_cart_pkg::mbc_none}))
			ram_bank_eff = 4'd0;      // unbanked ram
		else
			ram_bank_eff = regs.ram_bank & cart_info.ram_mask;

		if (cart_info.kind == gb_cart_pkg::mbc_none)
			rom_addr_next = {8'd0, cpu_req.addr[14:0]};
		else if (!cpu_req.addr[14])
			rom_addr_next = {9'd0, cpu_req.addr[13:0]};   // fixed bank 0
		else
			rom_addr_next = 23'(rom_bank_eff & cart_info.rom_mask)
				* 23'(gb_cart_pkg::rom_bank_bytes) + 23'(cpu_req.addr[13:0]);
	end

	assign ram_addr = 17'(ram_bank_eff) * 17'(gb_cart_pkg::ram_bank_bytes)
		+ 17'(cpu_req.addr[12:0]);
	assign ram_wr   = cpu_req.wr && is_ram && regs.ram_en && !rtc_mode;

	// ------------------------------------------------------------
	// response, one cycle after the read strobe
	// ------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_rd_q    <= 1'b0;
			ram_valid_q <= 1'b0;
		end else begin
			rom_rd_q    <= cpu_req.rd && is_rom;
			ram_valid_q <= cpu_req.rd && is_ram;
		end
		rom_addr_q <= rom_addr_next;
		off_q      <= !regs.ram_en;
		rtc_q      <= rtc_mode;
		mbc2_q     <= (cart_info.kind == gb_cart_pkg::mbc2);  // 4-bit wide ram
	end

	assign cpu_rsp.rom_rd    = rom_rd_q;
	assign cpu_rsp.rom_addr  = rom_addr_q;
	assign cpu_rsp.ram_valid = ram_valid_q;
	assign cpu_rsp.ram_data  = off_q ? 8'hff : rtc_q ? 8'h00 : mbc2_q ? {4'hf, ram_q[3:0]} : ram_q;

endmodule

// File: cart_header_capture.sv
// cartridge header capture
`timescale 1ns/1ps

module cart_header_capture (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   download,
	input  gb_cart_pkg::dl_word_t  dl_word,
	output gb_cart_pkg::cart_info_t cart_info
);

	logic [7:0] type_byte;  // 0x147
	logic [7:0] rom_size;   // 0x148
	logic [7:0] ram_size;   // 0x149

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			type_byte <= 8'd0;
			rom_size  <= 8'd0;
			ram_size  <= 8'd0;
		end else if (download && dl_word.wr) begin
			case (dl_word.addr)
				25'h146: type_byte <= dl_word.data[15:8];     // odd byte of the word
				25'h148: {ram_size, rom_size} <= dl_word.data;
				default: ;
			endcase
		end
	end

	// ------------------------------------------------------------
	// header decode
	// ------------------------------------------------------------
	always_comb begin
		if (type_byte inside {[8'd1:8'd3]})        cart_info.kind = gb_cart_pkg::mbc1;
		else if (type_byte inside {[8'd5:8'd6]})   cart_info.kind = gb_cart_pkg::mbc2;
		else if (type_byte inside {[8'd15:8'd19]}) cart_info.kind = gb_cart_pkg::mbc3;
		else if (type_byte inside {[8'd25:8'd30]}) cart_info.kind = gb_cart_pkg::mbc5;
		else                                       cart_info.kind = gb_cart_pkg::mbc_none;

		// 2^(n+1) banks, odd sizes fall back to 128
		if (rom_size <= 8'd8) cart_info.rom_mask = 9'((10'd2 << rom_size[3:0]) - 10'd1);
		else                  cart_info.rom_mask = 9'd127;

		if (ram_size <= 8'd2)       cart_info.ram_mask = 4'd0;  // single bank or less
		else if (ram_size == 8'd3)  cart_info.ram_mask = 4'd3;
		else                        cart_info.ram_mask = 4'd15;

		// sectors of 512 bytes minus one
		if (cart_info.kind == gb_cart_pkg::mbc2) cart_info.last_sector = 8'd1;
		else if (ram_size == 8'd1)               cart_info.last_sector = 8'd3;
		else if (ram_size == 8'd2)               cart_info.last_sector = 8'd15;
		else if (ram_size == 8'd3)               cart_info.last_sector = 8'd63;
		else                                     cart_info.last_sector = 8'd255;
	end

	a_dl_in_download: assert property (@(posedge clk_sys) disable iff (reset)
		dl_word.wr |-> download)
		else $error("download word strobe outside download");

endmodule

// File: cart_ram.sv
// cartridge ram, cpu byte port and backup word port
`timescale 1ns/1ps

module cart_ram #(
	parameter int ram_banks = 16
) (
	input  logic                     clk_sys,
	input  logic [16:0]              ram_addr,
	input  logic                     ram_wr,
	input  logic [7:0]               cpu_data,
	output logic [7:0]               ram_q,
	input  gb_backup_pkg::buff_word_t buff_word,
	input  logic [7:0]               bk_lba,
	output logic [15:0]              buff_q,
	output logic                     buff_q_valid
);

	localparam int words = ram_banks * gb_cart_pkg::ram_bank_bytes / 2;
	localparam int aw    = $clog2(words);

	logic [aw-1:0] cpu_word;
	logic [15:0]   bk_full;
	logic [aw-1:0] bk_word;
	logic          cpu_odd_q;  // byte lane of the pending cpu read

	assign cpu_word = ram_addr[aw:1];
	assign bk_full  = 16'(bk_lba) * 16'(gb_backup_pkg::sector_words) + 16'(buff_word.addr);
	assign bk_word  = bk_full[aw-1:0];   // wraps for smaller ram configs

	// lane 0 holds even bytes, lane 1 odd bytes
	for (genvar lane = 0; lane < 2; lane++) begin : g_lane
		logic [7:0] mem [words];
		logic       cpu_we;
		logic [7:0] cpu_q;
		logic [7:0] bk_q;

		assign cpu_we = ram_wr && (ram_addr[0] == 1'(lane));

		always_ff @(posedge clk_sys) begin
			if (cpu_we)
				mem[cpu_word] <= cpu_data;
			if (buff_word.wr)
				mem[bk_word] <= buff_word.data[8*lane +: 8];
			cpu_q <= mem[cpu_word];
			bk_q  <= mem[bk_word];
		end
	end

	always_ff @(posedge clk_sys) begin
		cpu_odd_q    <= ram_addr[0];
		buff_q_valid <= buff_word.rd;   // host data follows the rd strobe
	end

	assign ram_q  = cpu_odd_q ? g_lane[1].cpu_q : g_lane[0].cpu_q;
	assign buff_q = {g_lane[1].bk_q, g_lane[0].bk_q};

	// cpu side is blocked during loads, so the ports never collide
	a_no_port_clash: assert property (@(posedge clk_sys)
		!(ram_wr && buff_word.wr && (cpu_word == bk_word)))
		else $error("cpu and backup write the same ram word");

endmodule

// File: gb_backup_pkg.sv
// backup ram sector transfer types
package gb_backup_pkg;

	localparam int sector_words   = 256;                  // 512 bytes per sector
	localparam int buff_addr_bits = $clog2(sector_words);
	localparam int lba_bits       = 8;                    // 256 sectors cover 128k

	// request towards the host, one-cycle strobes
	typedef struct packed {
		logic                rd;       // load: host sends sector data
		logic                wr;       // save: host fetches sector data
		logic [lba_bits-1:0] lba;
	} sector_req_t;

	// host access into the sector buffer window
	typedef struct packed {
		logic                      wr;
		logic                      rd;
		logic [buff_addr_bits-1:0] addr;
		logic [15:0]               data;
	} buff_word_t;

endpackage

// File: gb_cart.f
gb_cart_pkg.sv
gb_backup_pkg.sv
cart_header_capture.sv
mbc_bank_regs.sv
cart_addr_map.sv
cart_ram.sv
backup_sequencer.sv
sector_counter.sv
gb_cart_top.sv
tb_gb_cart.sv

// File: gb_cart_pkg.sv
// cartridge bus and controller types
package gb_cart_pkg;

	// ------------------------------------------------------------
	// controller kinds and bank geometry
	// ------------------------------------------------------------
	typedef enum logic [2:0] {
		mbc_none = 3'd0,    // 32k linear rom, no banking
		mbc1     = 3'd1,
		mbc2     = 3'd2,
		mbc3     = 3'd3,
		mbc5     = 3'd4
	} mbc_kind_t;

	localparam int rom_bank_bits  = 9;      // 512 banks max on mbc5
	localparam int ram_bank_bits  = 4;      // 16 x 8k of cart ram
	localparam int rom_bank_bytes = 16384;
	localparam int ram_bank_bytes = 8192;

	// ------------------------------------------------------------
	// bus structs
	// ------------------------------------------------------------
	typedef struct packed {
		logic        rd;
		logic        wr;
		logic [15:0] addr;
		logic [7:0]  data;
	} cpu_req_t;

	typedef struct packed {
		logic        rom_rd;
		logic [22:0] rom_addr;    // byte address into rom storage
		logic        ram_valid;
		logic [7:0]  ram_data;
	} cpu_rsp_t;

	typedef struct packed {
		logic        wr;
		logic [24:0] addr;
		logic [15:0] data;        // odd byte in the high half
	} dl_word_t;

	typedef struct packed {
		logic [rom_bank_bits-1:0] rom_bank;
		logic [ram_bank_bits-1:0] ram_bank;
		logic                     mbc1_mode;
		logic                     rtc_sel;
		logic                     ram_en;
	} bank_regs_t;

	typedef struct packed {
		mbc_kind_t                kind;
		logic [rom_bank_bits-1:0] rom_mask;
		logic [ram_bank_bits-1:0] ram_mask;
		logic [7:0]               last_sector;
	} cart_info_t;

	// data byte written to 4000-5fff, seen two ways
	typedef struct packed {
		logic [3:0] unused_hi;
		logic       rtc;          // 1 maps rtc at a000, 0 maps ram
		logic       unused_lo;
		logic [1:0] bank;
	} mbc3_bank_wr_t;

	typedef struct packed {
		logic [3:0] unused_hi;
		logic [3:0] bank;
	} mbc5_bank_wr_t;

	typedef union packed {
		mbc3_bank_wr_t mbc3_view; // also used by mbc1 and mbc2
		mbc5_bank_wr_t mbc5_view;
	} ram_bank_wr_u;

endpackage

// File: gb_cart_top.sv
// game console cartridge top
`timescale 1ns/1ps

module gb_cart_top #(
	parameter int ram_banks = 16
) (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       download,
	input  gb_cart_pkg::dl_word_t      dl_word,
	input  gb_cart_pkg::cpu_req_t      cpu_req,
	output gb_cart_pkg::cpu_rsp_t      cpu_rsp,
	input  logic                       bk_load,
	input  logic                       bk_save,
	input  logic                       sector_done,
	output gb_backup_pkg::sector_req_t sector_req,
	input  gb_backup_pkg::buff_word_t  buff_word,
	output logic [15:0]                buff_q,
	output logic                       buff_q_valid,
	output logic                       bk_busy
);

	gb_cart_pkg::cart_info_t cart_info;
	gb_cart_pkg::bank_regs_t regs;
	gb_cart_pkg::cpu_req_t   cpu_req_act;    // cpu bus with strobes masked during load
	logic [16:0]             ram_addr;
	logic                    ram_wr;
	logic [7:0]              ram_q;
	logic                    loading, step, clear, last_sector_hit;
	logic [7:0]              lba;

	assign cpu_req_act = '{rd: cpu_req.rd && !loading, wr: cpu_req.wr && !loading,
		addr: cpu_req.addr, data: cpu_req.data};

	// ------------------------------------------------------------
	// cartridge side
	// ------------------------------------------------------------
	cart_header_capture i_header (.clk_sys, .reset, .download, .dl_word, .cart_info);

	mbc_bank_regs #(.ram_banks(ram_banks)) i_bank_regs (.clk_sys, .reset, .download,
		.loading, .cpu_req(cpu_req_act), .cart_info, .regs);

	cart_addr_map i_addr_map (.clk_sys, .reset, .cpu_req(cpu_req_act), .regs, .cart_info,
		.ram_q, .ram_addr, .ram_wr, .cpu_rsp);

	cart_ram #(.ram_banks(ram_banks)) i_ram (.clk_sys, .ram_addr, .ram_wr,
		.cpu_data(cpu_req.data), .ram_q, .buff_word, .bk_lba(lba), .buff_q, .buff_q_valid);

	// ------------------------------------------------------------
	// backup
	// ------------------------------------------------------------
	backup_sequencer i_backup (.clk_sys, .reset, .bk_load, .bk_save, .sector_done,
		.last_sector_hit, .lba, .step, .clear, .loading, .bk_busy, .sector_req);

	sector_counter i_sector_cnt (.clk_sys, .clear, .step,
		.last_sector(cart_info.last_sector), .lba, .last_sector_hit);

endmodule

// File: mbc_bank_regs.sv
// memory bank controller registers
`timescale 1ns/1ps

module mbc_bank_regs #(
	parameter int ram_banks = 16
) (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    download,
	input  logic                    loading,
	input  gb_cart_pkg::cpu_req_t   cpu_req,
	input  gb_cart_pkg::cart_info_t cart_info,
	output gb_cart_pkg::bank_regs_t regs
);

	localparam logic [3:0] bank_limit = 4'(ram_banks - 1); // physical ram bank wrap

	gb_cart_pkg::ram_bank_wr_u bank_wr;
	logic                      is_mbc3;
	logic                      is_mbc5;

	assign bank_wr = cpu_req.data;
	assign is_mbc3 = (cart_info.kind == gb_cart_pkg::mbc3);
	assign is_mbc5 = (cart_info.kind == gb_cart_pkg::mbc5);

	always_ff @(posedge clk_sys) begin
		if (reset || download || loading) begin
			regs <= '{rom_bank: 9'd1, default: '0};
		end else if (cpu_req.wr) begin
			case (cpu_req.addr[15:13])
				3'b000: regs.ram_en <= (cpu_req.data[3:0] == 4'ha);   // 0000-1fff
				3'b001: begin                                         // 2000-3fff
					if (is_mbc5) begin
						if (cpu_req.addr[12]) regs.rom_bank[8] <= cpu_req.data[0];
						else                  regs.rom_bank[7:0] <= cpu_req.data;
					end else if (cpu_req.data[6:0] == 7'd0) begin
						regs.rom_bank <= 9'd1;    // bank 0 is not selectable here
					end else begin
						regs.rom_bank <= {2'b00, cpu_req.data[6:0]};
					end
				end
				3'b010: begin                                         // 4000-5fff
					regs.rtc_sel <= is_mbc3 && bank_wr.mbc3_view.rtc;
					if (is_mbc5)
						regs.ram_bank <= bank_wr.mbc5_view.bank & bank_limit;
					else if (!(is_mbc3 && bank_wr.mbc3_view.rtc))
						regs.ram_bank <= {2'b00, bank_wr.mbc3_view.bank} & bank_limit;
				end
				3'b011: begin                                         // 6000-7fff
					if (cart_info.kind == gb_cart_pkg::mbc1) regs.mbc1_mode <= cpu_req.data[0];
				end
				default: ;  // writes above 0x8000 are not ours
			endcase
		end
	end

	// holds across later header changes too, bank 0 only reachable on mbc5
	a_rom_bank_nonzero: assert property (@(posedge clk_sys) disable iff (reset)
		(cart_info.kind inside {gb_cart_pkg::mbc1, gb_cart_pkg::mbc2, gb_cart_pkg::mbc3})
		|-> (regs.rom_bank != 9'd0))
		else $error("rom bank 0 selected on mbc1-3");

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the cartridge testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_gb_cart \
	-f gb_cart.f -o sim_gb_cart
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

./obj_dir/sim_gb_cart > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "All tests passed!" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

// File: sector_counter.sv
// backup sector counter
`timescale 1ns/1ps

module sector_counter (
	input  logic       clk_sys,
	input  logic       clear,
	input  logic       step,
	input  logic [7:0] last_sector,
	output logic [7:0] lba,
	output logic       last_sector_hit
);

	// sector number of the running backup
	always_ff @(posedge clk_sys) begin
		if (clear) begin
			lba <= 8'd0;
		end else if (step) begin
			lba <= lba + 8'd1;
		end
	end

	assign last_sector_hit = (lba == last_sector);   // final sector of this ram size

endmodule

// File: tb_gb_cart.sv
// cartridge core testbench
`timescale 1ns/1ps

module tb_gb_cart;

	logic                       clk_sys = 1'b0;
	logic                       reset;
	logic                       download;
	gb_cart_pkg::dl_word_t      dl_word;
	gb_cart_pkg::cpu_req_t      cpu_req;
	gb_cart_pkg::cpu_rsp_t      cpu_rsp;
	logic                       bk_load;
	logic                       bk_save;
	logic                       sector_done;
	gb_backup_pkg::sector_req_t sector_req;
	gb_backup_pkg::buff_word_t  buff_word;
	logic [15:0]                buff_q;
	logic                       buff_q_valid;
	logic                       bk_busy;

	integer      seed = 74;
	logic [15:0] ram_image [4096];    // 16 sectors of backup words, 8k bytes

	always #2 clk_sys = ~clk_sys;     // 4 ns period

	gb_cart_top #(.ram_banks(16)) i_gb_cart_top (.clk_sys, .reset, .download, .dl_word,
		.cpu_req, .cpu_rsp, .bk_load, .bk_save, .sector_done, .sector_req, .buff_word,
		.buff_q, .buff_q_valid, .bk_busy);

	// ------------------------------------------------------------
	// error handling and expected values
	// ------------------------------------------------------------
	task automatic stop_on_error();
		$display("Test failures found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("mismatch at %0d ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	// bank times 16k plus offset inside the bank
	function automatic logic [31:0] rom_byte_addr(input logic [8:0] bank,
		input logic [15:0] addr);
		return 32'(bank) * 32'(gb_cart_pkg::rom_bank_bytes) + 32'(addr[13:0]);
	endfunction

	// even byte sits in the low half of a backup word
	function automatic logic [7:0] image_byte(input logic [12:0] byte_addr);
		logic [15:0] word;
		word = ram_image[byte_addr[12:1]];
		return byte_addr[0] ? word[15:8] : word[7:0];
	endfunction

	function automatic logic request_seen(input logic is_load);
		return is_load ? sector_req.rd : sector_req.wr;
	endfunction

	// ------------------------------------------------------------
	// bus helpers
	// ------------------------------------------------------------
	task automatic download_header(input logic [7:0] cart_type, input logic [7:0] rom_size,
		input logic [7:0] ram_size);
		@(posedge clk_sys);
		download <= 1'b1;
		@(posedge clk_sys);
		dl_word <= '{wr: 1'b1, addr: 25'h146, data: {cart_type, 8'h00}};  // 0x147 is odd
		@(posedge clk_sys);
		dl_word <= '{wr: 1'b1, addr: 25'h148, data: {ram_size, rom_size}};
		@(posedge clk_sys);
		dl_word.wr <= 1'b0;
		@(posedge clk_sys);
		download <= 1'b0;     // bank regs were held at reset values meanwhile
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk_sys);
		cpu_req <= '{rd: 1'b0, wr: 1'b1, addr: addr, data: data};
		@(posedge clk_sys);
		cpu_req.wr <= 1'b0;
	endtask

	// response is registered one cycle after the strobe, sampled mid cycle
	task automatic cpu_read(input logic [15:0] addr, output gb_cart_pkg::cpu_rsp_t rsp);
		@(posedge clk_sys);
		cpu_req <= '{rd: 1'b1, wr: 1'b0, addr: addr, data: 8'h00};
		@(posedge clk_sys);
		cpu_req.rd <= 1'b0;
		@(negedge clk_sys);
		rsp = cpu_rsp;
	endtask

	task automatic check_rom(input logic [15:0] addr, input logic [31:0] exp_addr);
		gb_cart_pkg::cpu_rsp_t rsp;
		cpu_read(addr, rsp);
		check_value("cpu_rsp.rom_rd", 32'(rsp.rom_rd), 32'd1);
		check_value("cpu_rsp.rom_addr", 32'(rsp.rom_addr), exp_addr);
	endtask

	task automatic check_ram(input logic [15:0] addr, input logic [7:0] exp_data);
		gb_cart_pkg::cpu_rsp_t rsp;
		cpu_read(addr, rsp);
		check_value("cpu_rsp.ram_valid", 32'(rsp.ram_valid), 32'd1);
		check_value("cpu_rsp.ram_data", 32'(rsp.ram_data), 32'(exp_data));
	endtask

	task automatic start_backup(input logic is_load);
		@(posedge clk_sys);
		if (is_load)
			bk_load <= 1'b1;
		else
			bk_save <= 1'b1;
		@(posedge clk_sys);
		bk_load <= 1'b0;
		bk_save <= 1'b0;
	endtask

	// one sector between host and ram, load writes words and save reads them back
	task automatic move_sector(input logic is_load, input int lba);
		int                    wait_cycles;
		int                    base;
		gb_cart_pkg::cpu_rsp_t rsp;
		wait_cycles = 0;
		base = lba * gb_backup_pkg::sector_words;
		@(negedge clk_sys);
		while (!request_seen(is_load) && wait_cycles < 50) begin
			@(negedge clk_sys);
			wait_cycles++;
		end
		if (!request_seen(is_load)) begin
			$display("timeout: no sector request for lba %0d", lba);
			stop_on_error();
		end
		check_value("sector_req.lba", 32'(sector_req.lba), 32'(lba));
		check_value("bk_busy", 32'(bk_busy), 32'd1);
		if (is_load && lba == 0) begin
			cpu_read(16'ha000, rsp);     // cpu port is shut during a load
			check_value("cpu_rsp.ram_valid", 32'(rsp.ram_valid), 32'd0);
		end
		for (int a = 0; a < gb_backup_pkg::sector_words; a++) begin
			@(posedge clk_sys);
			if (is_load) begin
				buff_word <= '{wr: 1'b1, rd: 1'b0, addr: 8'(a), data: ram_image[base + a]};
			end else begin
				buff_word <= '{wr: 1'b0, rd: 1'b1, addr: 8'(a), data: 16'h0000};
				@(posedge clk_sys);
				buff_word.rd <= 1'b0;
				@(negedge clk_sys);
				check_value("buff_q_valid", 32'(buff_q_valid), 32'd1);
				check_value("buff_q", 32'(buff_q), 32'(ram_image[base + a]));
			end
		end
		@(posedge clk_sys);
		buff_word.wr <= 1'b0;
		sector_done  <= 1'b1;
		@(posedge clk_sys);
		sector_done <= 1'b0;
	endtask

	task automatic wait_backup_idle();
		int wait_cycles;
		wait_cycles = 0;
		@(negedge clk_sys);
		while (bk_busy && wait_cycles < 20) begin
			@(negedge clk_sys);
			wait_cycles++;
		end
		if (bk_busy) begin
			$display("timeout: bk_busy stayed high after the last sector");
			stop_on_error();
		end
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic test_reset_state();
		check_value("cpu_rsp.rom_rd", 32'(cpu_rsp.rom_rd), 32'd0);
		check_value("cpu_rsp.ram_valid", 32'(cpu_rsp.ram_valid), 32'd0);
		check_value("sector_req.rd", 32'(sector_req.rd), 32'd0);
		check_value("sector_req.wr", 32'(sector_req.wr), 32'd0);
		check_value("bk_busy", 32'(bk_busy), 32'd0);
		check_value("buff_q_valid", 32'(buff_q_valid), 32'd0);
	endtask

	task automatic test_mbc1_rom_banking();
		download_header(8'd1, 8'd4, 8'd3);       // 32 rom banks, mask 0x1f
		cpu_write(16'h2000, 8'h00);              // bank 0 turns into 1
		check_rom(16'h4123, rom_byte_addr(9'd1, 16'h4123));
		cpu_write(16'h2000, 8'h25);
		check_rom(16'h4123, rom_byte_addr(9'h25 & 9'h01f, 16'h4123));
		cpu_write(16'h4000, 8'h01);              // bit 5 via ram bank lines, masked off here
		check_rom(16'h7fff, rom_byte_addr(9'h25 & 9'h01f, 16'h7fff));
		check_rom(16'h0100, 32'h0000_0100);
		download_header(8'd1, 8'd6, 8'd3);       // 128 banks so bits 6:5 show
		cpu_write(16'h2000, 8'h05);
		cpu_write(16'h4000, 8'h01);
		check_rom(16'h4123, rom_byte_addr(9'h025, 16'h4123));
		cpu_write(16'h4000, 8'h02);
		check_rom(16'h4123, rom_byte_addr(9'h045, 16'h4123));
		check_rom(16'h0100, 32'h0000_0100);      // low window stays on bank 0
	endtask

	task automatic test_ram_enable();
		logic [7:0] byte0;
		logic [7:0] byte1;
		logic [7:0] byte2;
		byte0 = 8'($random(seed));
		byte1 = byte0 ^ 8'h3c;
		byte2 = byte0 ^ 8'hc3;
		download_header(8'd3, 8'd4, 8'd3);
		check_ram(16'ha010, 8'hff);              // still disabled
		cpu_write(16'h0000, 8'h0a);
		cpu_write(16'ha010, byte0);
		check_ram(16'ha010, byte0);
		cpu_write(16'h6000, 8'h01);              // mode 1, banked ram
		cpu_write(16'h4000, 8'h01);
		cpu_write(16'ha010, byte1);
		cpu_write(16'h4000, 8'h02);
		cpu_write(16'ha010, byte2);
		cpu_write(16'h4000, 8'h00);
		check_ram(16'ha010, byte0);
		cpu_write(16'h4000, 8'h01);
		check_ram(16'ha010, byte1);
		cpu_write(16'h4000, 8'h02);
		check_ram(16'ha010, byte2);
	endtask

	task automatic test_mbc5();
		logic [7:0] byte_lo;
		logic [7:0] byte_hi;
		byte_lo = 8'($random(seed));
		byte_hi = ~byte_lo;
		download_header(8'd25, 8'd8, 8'd4);      // 512 rom banks, 16 ram banks
		cpu_write(16'h2000, 8'ha3);
		cpu_write(16'h3000, 8'h01);              // rom bank bit 8
		check_rom(16'h5abc, rom_byte_addr(9'h1a3, 16'h5abc));
		cpu_write(16'h0000, 8'h0a);
		cpu_write(16'h4000, 8'h09);
		cpu_write(16'hb001, byte_hi);
		cpu_write(16'h4000, 8'h00);
		cpu_write(16'hb001, byte_lo);
		check_ram(16'hb001, byte_lo);
		cpu_write(16'h4000, 8'h09);
		check_ram(16'hb001, byte_hi);
		download_header(8'd16, 8'd4, 8'd3);      // now mbc3
		cpu_write(16'h0000, 8'h0a);
		cpu_write(16'h4000, 8'h08);              // rtc select
		check_ram(16'hb001, 8'h00);
		cpu_write(16'h4000, 8'h00);
		check_ram(16'hb001, byte_lo);            // ram kept across header change
	endtask

	task automatic test_mbc2();
		logic [7:0] data;
		data = 8'($random(seed));
		download_header(8'd5, 8'd2, 8'd0);
		cpu_write(16'h0000, 8'h0a);
		cpu_write(16'ha003, data);
		check_ram(16'ha003, {4'hf, data[3:0]}); // nibble wide ram
	endtask

	task automatic test_backup();
		logic [12:0] byte_addr;
		download_header(8'd3, 8'd4, 8'd2);       // 8k ram, last sector 15
		for (int i = 0; i < 4096; i++)
			ram_image[i] = 16'($random(seed));
		start_backup(1'b1);
		for (int lba = 0; lba < 16; lba++)
			move_sector(1'b1, lba);
		wait_backup_idle();
		cpu_write(16'h0000, 8'h0a);              // regs were held at reset during load
		for (int i = 0; i < 8; i++) begin
			byte_addr = 13'($random(seed));
			check_ram(16'ha000 + 16'(byte_addr), image_byte(byte_addr));
		end
		check_ram(16'hbfff, image_byte(13'h1fff));
		start_backup(1'b0);
		for (int lba = 0; lba < 16; lba++)
			move_sector(1'b0, lba);
		wait_backup_idle();
	endtask

	// ------------------------------------------------------------
	// run
	// ------------------------------------------------------------
	initial begin
		reset       = 1'b1;
		download    = 1'b0;
		dl_word     = '0;
		cpu_req     = '0;
		bk_load     = 1'b0;
		bk_save     = 1'b0;
		sector_done = 1'b0;
		buff_word   = '0;
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);
		test_reset_state();
		test_mbc1_rom_banking();
		test_ram_enable();
		test_mbc5();
		test_mbc2();
		test_backup();
		$display("All tests passed!");
		$finish;
	end

endmodule
